// ==== logic/ex_mem_pkg.sv ====
package ex_mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [21:0] pc_t;      // instruction address
	typedef logic [4:0]  reg_idx_t;

	parameter int DMEM_ADDR_BITS_DEFAULT = 8;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_sll    = 3'd5,
		alu_srl    = 3'd6,
		alu_pass_t = 3'd7      // forwards t operand
	} alu_op_t;

	typedef enum logic [2:0] {
		br_neq    = 3'd0,
		br_eq     = 3'd1,
		br_gt     = 3'd2,
		br_lt     = 3'd3,
		br_gte    = 3'd4,
		br_lte    = 3'd5,
		br_ovfl   = 3'd6,
		br_uncond = 3'd7
	} branch_cond_t;

	// instruction as issued by decode
	typedef struct packed {
		logic         valid;
		alu_op_t      alu_op;
		word_t        s_data;
		word_t        t_data;
		word_t        sprite_data;
		reg_idx_t     dst_reg;
		logic         use_dst_reg;
		logic         re;
		logic         we;
		logic         mem_alu_select;
		logic         use_sprite_mem;
		logic         is_branch;
		branch_cond_t branch_cond;
		pc_t          pc;
		pc_t          pc_out;  // branch target
	} ex_req_t;

	typedef struct packed {
		logic         valid;
		logic         ov;
		logic         neg;
		logic         zero;
		word_t        alu_result;
		word_t        s_data;
		word_t        t_data;
		word_t        sprite_data;
		reg_idx_t     dst_reg;
		logic         use_dst_reg;
		logic         re;
		logic         we;
		logic         mem_alu_select;
		logic         use_sprite_mem;
		logic         is_branch;
		branch_cond_t branch_cond;
		pc_t          pc;
		pc_t          pc_out;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;  // register write happens
		reg_idx_t dst_reg;
		word_t    data;
	} wb_t;

endpackage

// ==== logic/alu_stage.sv ====
`timescale 1ns/1ns

module alu_stage import ex_mem_pkg::*; (
	input  ex_req_t req,
	output ex_mem_t ex_out
);

	word_t result;
	logic  ov;
	logic  s_sign;
	logic  t_sign;
	logic  r_sign;

	always_comb begin
		case (req.alu_op)
			alu_add:    result = req.s_data + req.t_data;
			alu_sub:    result = req.s_data - req.t_data;
			alu_and:    result = req.s_data & req.t_data;
			alu_or:     result = req.s_data | req.t_data;
			alu_xor:    result = req.s_data ^ req.t_data;
			alu_sll:    result = req.s_data << req.t_data[4:0];
			alu_srl:    result = req.s_data >> req.t_data[4:0];
			alu_pass_t: result = req.t_data;
			default:    result = '0;
		endcase
	end

	assign s_sign = req.s_data[31];
	assign t_sign = req.t_data[31];
	assign r_sign = result[31];

	// signed overflow, only add and sub can raise it
	always_comb begin
		case (req.alu_op)
			alu_add: ov = (s_sign == t_sign) && (r_sign != s_sign);
			alu_sub: ov = (s_sign != t_sign) && (r_sign != s_sign);
			default: ov = 1'b0;
		endcase
	end

	always_comb begin
		ex_out                = '0;
		ex_out.valid          = req.valid;
		ex_out.ov             = ov;
		ex_out.neg            = r_sign;
		ex_out.zero           = (result == '0);
		ex_out.alu_result     = result;
		ex_out.s_data         = req.s_data;
		ex_out.t_data         = req.t_data;  // store data
		ex_out.sprite_data    = req.sprite_data;
		ex_out.dst_reg        = req.dst_reg;
		ex_out.use_dst_reg    = req.use_dst_reg;
		ex_out.re             = req.re;
		ex_out.we             = req.we;
		ex_out.mem_alu_select = req.mem_alu_select;
		ex_out.use_sprite_mem = req.use_sprite_mem;
		ex_out.is_branch      = req.is_branch;
		ex_out.branch_cond    = req.branch_cond;
		ex_out.pc             = req.pc;
		ex_out.pc_out         = req.pc_out;
	end

	// decode must never issue an undefined operation
	always_comb begin
		if (req.valid) begin
			assert ($isunknown(req.alu_op) == 1'b0)
				else $error("alu_stage: unknown alu_op on a valid instruction");
		end
	end

endmodule

// ==== logic/ex_mem_pipeline_reg.sv ====
`timescale 1ns/1ns

module ex_mem_pipeline_reg import ex_mem_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    hlt,
	input  logic    flush,
	input  ex_mem_t ex_out,
	output ex_mem_t mem_in
);

	// whole bundle clears, control bits included
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_in <= '0;
		end else if (flush) begin
			mem_in <= '0;  // drop younger instruction
		end else if (!hlt) begin
			mem_in <= ex_out;
		end
	end

	// a flushed slot carries no instruction into MEM
	a_flush_clears: assert property (
		@(posedge clk) disable iff (!rst_n)
		(flush && !hlt) |=> !mem_in.valid
	) else $error("ex_mem_pipeline_reg: valid instruction survived a flush");

endmodule

// ==== logic/branch_resolver.sv ====
`timescale 1ns/1ns

module branch_resolver import ex_mem_pkg::*; (
	input  ex_mem_t mem_in,
	output logic    branch_taken,
	output pc_t     branch_target,
	output logic    flush
);

	logic cond_met;

	always_comb begin
		case (mem_in.branch_cond)
			br_neq:    cond_met = !mem_in.zero;
			br_eq:     cond_met = mem_in.zero;
			br_gt:     cond_met = !mem_in.neg && !mem_in.zero;
			br_lt:     cond_met = mem_in.neg;
			br_gte:    cond_met = !mem_in.neg;
			br_lte:    cond_met = mem_in.neg || mem_in.zero;
			br_ovfl:   cond_met = mem_in.ov;
			br_uncond: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	assign branch_taken = mem_in.valid && mem_in.is_branch && cond_met;

	// fall-through is the next sequential word
	assign branch_target = branch_taken ? mem_in.pc_out : mem_in.pc + pc_t'(1);

	assign flush = branch_taken;  // kill the instruction now in EX

endmodule

// ==== logic/data_memory_stage.sv ====
`timescale 1ns/1ns

module data_memory_stage import ex_mem_pkg::*; #(
	parameter int DMEM_ADDR_BITS = DMEM_ADDR_BITS_DEFAULT
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    hlt,
	input  ex_mem_t mem_in,
	output wb_t     wb
);

	localparam int DEPTH = 1 << DMEM_ADDR_BITS;

	word_t                     mem [DEPTH];
	logic [DMEM_ADDR_BITS-1:0] addr;
	logic                      mem_write;
	word_t                     rd_data;
	word_t                     wb_data;

	// word address from the low bits of the ALU result
	assign addr = mem_in.alu_result[DMEM_ADDR_BITS-1:0];

	assign mem_write = mem_in.valid && mem_in.we && !hlt;

	// power-up contents are zero
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_write) begin
			mem[addr] <= mem_in.t_data;
		end
	end

	assign rd_data = mem[addr];  // async read, registered below

	always_comb begin
		if (mem_in.mem_alu_select) begin
			wb_data = rd_data;
		end else if (mem_in.use_sprite_mem) begin
			wb_data = mem_in.sprite_data;
		end else begin
			wb_data = mem_in.alu_result;
		end
	end

	// MEM/WB register, frozen while halted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else if (!hlt) begin
			wb.valid   <= mem_in.valid && mem_in.use_dst_reg;
			wb.dst_reg <= mem_in.dst_reg;
			wb.data    <= wb_data;
		end
	end

	// decode issues load and store as separate instructions
	a_no_load_store: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_in.valid |-> !(mem_in.re && mem_in.we)
	) else $error("data_memory_stage: re and we both set on one instruction");

endmodule

// ==== logic/ex_mem_backend.sv ====
`timescale 1ns/1ns

module ex_mem_backend import ex_mem_pkg::*; #(
	parameter int DMEM_ADDR_BITS = DMEM_ADDR_BITS_DEFAULT
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    hlt,
	input  ex_req_t ex_req,
	output wb_t     wb,
	output logic    branch_taken,
	output pc_t     branch_target
);

	ex_mem_t ex_out;
	ex_mem_t mem_in;
	logic    flush;
	logic    reg_flush;

	alu_stage u_alu_stage (
		.req    (ex_req),
		.ex_out (ex_out)
	);

	// halt freezes the redirect too, so the branch is not lost
	assign reg_flush = flush && !hlt;

	ex_mem_pipeline_reg u_ex_mem_reg (
		.clk    (clk),
		.rst_n  (rst_n),
		.hlt    (hlt),
		.flush  (reg_flush),
		.ex_out (ex_out),
		.mem_in (mem_in)
	);

	branch_resolver u_branch_resolver (
		.mem_in        (mem_in),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.flush         (flush)
	);

	data_memory_stage #(
		.DMEM_ADDR_BITS (DMEM_ADDR_BITS)
	) u_data_memory_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.hlt    (hlt),
		.mem_in (mem_in),
		.wb     (wb)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== verification/ex_mem_backend_tb.sv ====
`timescale 1ns/1ns

module ex_mem_backend_tb import ex_mem_pkg::*; ();

	localparam int ADDR_BITS    = 6;
	localparam int CLK_NS       = 100;
	localparam int RESET_CYCLES = 4;
	localparam int ALU_COUNT    = 32;
	localparam int MEM_PAIRS    = 8;
	localparam int COLD_LOADS   = 4;
	localparam int BRANCH_ISSUE = 8 * 4 * 2;  // cond x flag pattern x (branch, victim)
	localparam int SPRITE_COUNT = 5;
	localparam int HALT_ROUNDS  = 24;
	localparam int HALT_MAX     = 3;
	localparam int ISSUE_TOTAL  = 2 + ALU_COUNT + 2 * MEM_PAIRS + COLD_LOADS + BRANCH_ISSUE
		+ SPRITE_COUNT + HALT_ROUNDS + 3;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + ISSUE_TOTAL + HALT_ROUNDS * HALT_MAX + 20)
		* CLK_NS;

	logic    clk;
	logic    rst_n;
	logic    hlt;
	ex_req_t ex_req;
	wb_t     wb;
	logic    branch_taken;
	pc_t     branch_target;
	int      seed;
	int      wb_errors;
	int      branch_errors;
	int      other_errors;

	// reference model state
	ex_req_t slot;  // shadow of the EX/MEM slot
	wb_t     exp_wb;
	word_t   shadow_mem [1 << ADDR_BITS];
	logic    exp_taken;
	pc_t     exp_target;

	tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ex_mem_backend #(.DMEM_ADDR_BITS(ADDR_BITS)) dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.hlt           (hlt),
		.ex_req        (ex_req),
		.wb            (wb),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	function automatic word_t ref_result(ex_req_t r);
		case (r.alu_op)
			alu_add: return r.s_data + r.t_data;
			alu_sub: return r.s_data - r.t_data;
			alu_and: return r.s_data & r.t_data;
			alu_or:  return r.s_data | r.t_data;
			alu_xor: return r.s_data ^ r.t_data;
			alu_sll: return r.s_data << r.t_data[4:0];
			alu_srl: return r.s_data >> r.t_data[4:0];
			default: return r.t_data;
		endcase
	endfunction

	// overflow when the exact signed result does not fit 32 bits
	function automatic logic ref_overflow(ex_req_t r);
		longint wide;
		if (r.alu_op == alu_add) begin
			wide = longint'($signed(r.s_data)) + longint'($signed(r.t_data));
		end else if (r.alu_op == alu_sub) begin
			wide = longint'($signed(r.s_data)) - longint'($signed(r.t_data));
		end else begin
			return 1'b0;
		end
		return wide != longint'($signed(ref_result(r)));
	endfunction

	function automatic logic ref_taken(ex_req_t r);
		word_t res;
		logic  zero;
		logic  neg;
		res  = ref_result(r);
		zero = (res == 32'd0);
		neg  = res[31];
		if (!r.valid || !r.is_branch) begin
			return 1'b0;
		end
		case (r.branch_cond)
			br_neq:  return !zero;
			br_eq:   return zero;
			br_gt:   return !(neg || zero);
			br_lt:   return neg;
			br_gte:  return !neg;
			br_lte:  return neg || zero;
			br_ovfl: return ref_overflow(r);
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [ADDR_BITS-1:0] mem_addr(ex_req_t r);
		word_t res;
		res = ref_result(r);
		return res[ADDR_BITS-1:0];
	endfunction

	function automatic word_t wb_select(ex_req_t r);
		if (r.mem_alu_select) begin
			return shadow_mem[mem_addr(r)];
		end else if (r.use_sprite_mem) begin
			return r.sprite_data;
		end
		return ref_result(r);
	endfunction

	assign exp_taken  = ref_taken(slot);
	assign exp_target = exp_taken ? slot.pc_out : slot.pc + 22'd1;

	initial begin
		for (int i = 0; i < (1 << ADDR_BITS); i++) begin
			shadow_mem[i] = '0;
		end
	end

	// model moves only on unhalted edges
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot   <= '0;
			exp_wb <= '0;
		end else if (!hlt) begin
			exp_wb.valid   <= slot.valid && slot.use_dst_reg;
			exp_wb.dst_reg <= slot.dst_reg;
			exp_wb.data    <= wb_select(slot);
			if (slot.valid && slot.we) begin
				shadow_mem[mem_addr(slot)] <= slot.t_data;
			end
			if (exp_taken) begin
				slot <= '0;  // younger instruction dropped
			end else begin
				slot <= ex_req;
			end
		end
	end

	a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb.valid == exp_wb.valid)
		else begin
			wb_errors++;
			$display("CHECK FAILED at %0t ns: wb.valid is %b, expected %b", $time,
				$sampled(wb.valid), $sampled(exp_wb.valid));
		end

	a_wb_dst: assert property (@(posedge clk) disable iff (!rst_n)
		exp_wb.valid |-> wb.dst_reg == exp_wb.dst_reg)
		else begin
			wb_errors++;
			$display("CHECK FAILED at %0t ns: wb.dst_reg is %0d, expected %0d", $time,
				$sampled(wb.dst_reg), $sampled(exp_wb.dst_reg));
		end

	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		exp_wb.valid |-> wb.data == exp_wb.data)
		else begin
			wb_errors++;
			$display("CHECK FAILED at %0t ns: wb.data is %h, expected %h", $time,
				$sampled(wb.data), $sampled(exp_wb.data));
		end

	a_taken: assert property (@(posedge clk) disable iff (!rst_n) branch_taken == exp_taken)
		else begin
			branch_errors++;
			$display("CHECK FAILED at %0t ns: branch_taken is %b, expected %b", $time,
				$sampled(branch_taken), $sampled(exp_taken));
		end

	a_target: assert property (@(posedge clk) disable iff (!rst_n)
		branch_target == exp_target)
		else begin
			branch_errors++;
			$display("CHECK FAILED at %0t ns: branch_target is %h, expected %h", $time,
				$sampled(branch_target), $sampled(exp_target));
		end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb.valid && !branch_taken)
		else begin
			other_errors++;
			$display("wb.valid or branch_taken is high while reset is asserted (%0t ns)", $time);
		end

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic ex_req_t alu_req(alu_op_t op, word_t s, word_t t);
		ex_req_t r;
		word_t   pick;
		r             = '0;
		pick          = rand_word();
		r.valid       = 1'b1;
		r.alu_op      = op;
		r.s_data      = s;
		r.t_data      = t;
		r.dst_reg     = pick[4:0];
		r.use_dst_reg = 1'b1;
		r.pc          = pick[31:10];
		return r;
	endfunction

	// address is s - t, stored word is t
	function automatic ex_req_t store_req(word_t addr, word_t data);
		ex_req_t r;
		r             = alu_req(alu_sub, addr + data, data);
		r.we          = 1'b1;
		r.use_dst_reg = 1'b0;
		return r;
	endfunction

	function automatic ex_req_t load_req(word_t addr);
		ex_req_t r;
		r                = alu_req(alu_add, addr, 32'd0);
		r.re             = 1'b1;
		r.mem_alu_select = 1'b1;
		return r;
	endfunction

	function automatic ex_req_t branch_req(branch_cond_t cond, word_t s, word_t t);
		ex_req_t r;
		word_t   dest;
		dest          = rand_word();
		r             = alu_req(alu_sub, s, t);
		r.is_branch   = 1'b1;
		r.branch_cond = cond;
		r.pc_out      = dest[21:0];
		return r;
	endfunction

	task automatic issue(input ex_req_t r);
		@(posedge clk);
		ex_req <= r;
		hlt    <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) issue('0);
	endtask

	task automatic halt_for(input int n);
		repeat (n) begin
			@(posedge clk);
			hlt <= 1'b1;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("errors: wb %0d, branch %0d, other %0d", wb_errors, branch_errors,
			other_errors + 1);
		$display("Something failed");
		$finish;
	end

	initial begin
		ex_req_t r;
		word_t   a;
		word_t   rnd;
		seed          = 32'hf907_abd9;
		wb_errors     = 0;
		branch_errors = 0;
		other_errors  = 0;
		hlt           = 1'b0;
		ex_req        = '0;
		@(posedge rst_n);
		idle(2);
		for (int i = 0; i < ALU_COUNT; i++) begin
			r             = alu_req(alu_op_t'(i[2:0]), rand_word(), rand_word());
			rnd           = rand_word();
			r.use_dst_reg = (rnd[1:0] != 2'b00);
			issue(r);
		end
		for (int i = 0; i < MEM_PAIRS; i++) begin
			rnd = rand_word();
			a   = {27'd0, rnd[4:0]};
			issue(store_req(a, rand_word()));
			issue(load_req(a));
		end
		for (int i = 0; i < COLD_LOADS; i++) begin
			rnd = rand_word();
			issue(load_req({rnd[31:6], 1'b1, rnd[4:0]}));  // upper half of memory
		end
		for (int c = 0; c < 8; c++) begin
			for (int f = 0; f < 4; f++) begin
				case (f)
					0: r = branch_req(branch_cond_t'(c[2:0]), 32'd5, 32'd5);  // zero
					1: r = branch_req(branch_cond_t'(c[2:0]), 32'd1, 32'd2);  // negative
					2: r = branch_req(branch_cond_t'(c[2:0]), 32'd9, 32'd4);
					default: r = branch_req(branch_cond_t'(c[2:0]), 32'h8000_0000, 32'd1);
				endcase
				issue(r);
				issue(alu_req(alu_xor, rand_word(), rand_word()));
			end
		end
		for (int i = 0; i < SPRITE_COUNT; i++) begin
			r                = alu_req(alu_or, rand_word(), rand_word());
			r.use_sprite_mem = 1'b1;
			r.sprite_data    = rand_word();
			if (i == SPRITE_COUNT - 1) begin
				r.re             = 1'b1;
				r.mem_alu_select = 1'b1;  // memory read wins over sprite
			end
			issue(r);
		end
		for (int i = 0; i < HALT_ROUNDS; i++) begin
			rnd = rand_word();
			a   = {29'd0, rnd[2:0]};
			case (rnd[9:8])
				2'd0: r = alu_req(alu_op_t'(rnd[6:4]), rand_word(), rand_word());
				2'd1: r = store_req(a, rand_word());
				2'd2: r = load_req(a);
				default: r = branch_req(branch_cond_t'(rnd[6:4]), rand_word(), rand_word());
			endcase
			issue(r);
			halt_for(int'(rnd[13:12]));
		end
		idle(3);
		@(posedge clk);
		#1;
		$display("errors: wb %0d, branch %0d, other %0d", wb_errors, branch_errors,
			other_errors);
		if (wb_errors + branch_errors + other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== ex_mem_backend.f ====
logic/ex_mem_pkg.sv
logic/alu_stage.sv
logic/ex_mem_pipeline_reg.sv
logic/branch_resolver.sv
logic/data_memory_stage.sv
logic/ex_mem_backend.sv
verification/tb_clock_gen.sv
verification/ex_mem_backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the ex_mem_backend testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module ex_mem_backend_tb \
	-f ex_mem_backend.f \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

sim_out=$(./obj_dir/Vex_mem_backend_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
